// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the rv_top testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/10ps --top-module tb_rv_top -f rv_top.f \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/Vtb_rv_top > sim.log 2>&1 || { cat sim.log; echo "simulation run failed"; exit 1; }
cat sim.log
grep -q "TESTBENCH PASSED" sim.log && echo "result: pass" || { echo "result: fail"; exit 1; }

// ==== rv_alu.sv ====
//////////////////////////////////////////////////
// ALU for the RV32I subset core
// register and immediate ops, LUI, JAL link,
// branch compare and load/store address adder
//////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/10ps

module rv_alu (
    input  rv_pkg::opcode_t opcode_i,
    input  logic [2:0]      funct3_i,
    input  logic            alt_op_i,
    input  logic            imm_sel_i,
    input  rv_pkg::word_t   rs1_data_i,
    input  rv_pkg::word_t   rs2_data_i,
    input  rv_pkg::word_t   imm_i,
    input  rv_pkg::word_t   pc_i,
    output rv_pkg::word_t   result_o,
    output rv_pkg::word_t   addr_o,
    output logic            branch_taken_o
);
    import rv_pkg::*;

    word_t op_b;

    assign op_b = imm_sel_i ? imm_i : rs2_data_i;

    // effective address for LW and SW
    assign addr_o = rs1_data_i + imm_i;

    always_comb begin
        result_o = '0;
        case (opcode_i)
            OP_REG, OP_IMM: begin
                case (funct3_i)
                    F3_ADD:  result_o = alt_op_i ? rs1_data_i - op_b : rs1_data_i + op_b;
                    F3_SLL:  result_o = rs1_data_i << op_b[4:0];
                    F3_XOR:  result_o = rs1_data_i ^ op_b;
                    F3_SRL:  result_o = rs1_data_i >> op_b[4:0];
                    F3_OR:   result_o = rs1_data_i | op_b;
                    F3_AND:  result_o = rs1_data_i & op_b;
                    default: result_o = '0;
                endcase
            end
            OP_LUI:  result_o = imm_i;
            // link value is the address after the jump
            OP_JAL:  result_o = pc_i + INSTR_BYTES;
            default: result_o = '0;
        endcase
    end

    // blt and bge compare unsigned
    always_comb begin
        branch_taken_o = 1'b0;
        if (opcode_i == OP_BRANCH) begin
            case (funct3_i)
                F3_BEQ:  branch_taken_o = (rs1_data_i == rs2_data_i);
                F3_BNE:  branch_taken_o = (rs1_data_i != rs2_data_i);
                F3_BLT:  branch_taken_o = (rs1_data_i < rs2_data_i);
                F3_BGE:  branch_taken_o = (rs1_data_i >= rs2_data_i);
                default: branch_taken_o = 1'b0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rv_decoder.sv ====
//////////////////////////////////////////////////
// instruction register and field decoder
// register indices, funct3, sub bit, and the
// I, S, B, J and U immediates
//////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/10ps

module rv_decoder (
    input  logic              clk,
    input  logic              rst,
    input  logic              load_i,
    input  rv_pkg::word_t     instr_i,
    output rv_pkg::opcode_t   opcode_o,
    output rv_pkg::reg_addr_t rs1_o,
    output rv_pkg::reg_addr_t rs2_o,
    output rv_pkg::reg_addr_t rd_o,
    output logic [2:0]        funct3_o,
    output logic              alt_op_o,
    output rv_pkg::word_t     imm_o,
    output logic              imm_sel_o
);
    import rv_pkg::*;

    word_t ir;

    // instruction register, loaded when the fetch completes
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            ir <= '0;
        end else if (load_i) begin
            ir <= instr_i;
        end
    end

    assign opcode_o = ir[6:0];

    always_comb begin
        // fields not used by a format stay zero
        rs1_o     = '0;
        rs2_o     = '0;
        rd_o      = '0;
        funct3_o  = '0;
        alt_op_o  = 1'b0;
        imm_o     = '0;
        imm_sel_o = 1'b0;
        case (ir[6:0])
            OP_REG: begin
                rd_o     = ir[11:7];
                rs1_o    = ir[19:15];
                rs2_o    = ir[24:20];
                funct3_o = ir[14:12];
                alt_op_o = ir[30];
            end
            OP_IMM, OP_LOAD: begin
                rd_o      = ir[11:7];
                rs1_o     = ir[19:15];
                funct3_o  = ir[14:12];
                imm_o     = {{20{ir[31]}}, ir[31:20]};
                imm_sel_o = 1'b1;
            end
            OP_STORE: begin
                rs1_o     = ir[19:15];
                rs2_o     = ir[24:20];
                funct3_o  = ir[14:12];
                imm_o     = {{20{ir[31]}}, ir[31:25], ir[11:7]};
                imm_sel_o = 1'b1;
            end
            OP_BRANCH: begin
                // rs2 is the compare operand, the offset goes to the PC
                rs1_o    = ir[19:15];
                rs2_o    = ir[24:20];
                funct3_o = ir[14:12];
                imm_o    = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
            end
            OP_JAL: begin
                rd_o      = ir[11:7];
                imm_o     = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
                imm_sel_o = 1'b1;
            end
            OP_LUI: begin
                rd_o      = ir[11:7];
                imm_o     = {ir[31:12], 12'b0};
                imm_sel_o = 1'b1;
            end
            default: begin
                imm_sel_o = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== rv_pc.sv ====
//////////////////////////////////////////////////
// program counter, sequential step or
// relative jump by the decoded offset
//////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/10ps

module rv_pc (
    input  logic          clk,
    input  logic          rst,
    input  logic          step_i,
    input  logic          jump_i,
    input  rv_pkg::word_t offset_i,
    output rv_pkg::word_t pc_o
);
    import rv_pkg::*;

    word_t pc;

    // jump wins, the sequencer never raises both
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            pc <= RESET_PC;
        end else if (jump_i) begin
            pc <= pc + offset_i;
        end else if (step_i) begin
            pc <= pc + INSTR_BYTES;
        end
    end

    assign pc_o = pc;

endmodule

`default_nettype wire

// ==== rv_pkg.sv ====
//////////////////////////////////////////////////
// shared package for the RV32I subset core
// word and field types, opcode and funct3 codes,
// reset PC, PC step and Wishbone select constant
//////////////////////////////////////////////////

`default_nettype none

package rv_pkg;

    // data, address and instruction words
    typedef logic [31:0] word_t;

    // register index
    typedef logic [4:0] reg_addr_t;

    // major opcode field, instr[6:0]
    typedef logic [6:0] opcode_t;

    // opcode classes
    localparam opcode_t OP_REG    = 7'b0110011;
    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;

    // funct3 for register and immediate ALU ops
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLL = 3'b001;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_SRL = 3'b101;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    // funct3 for branches
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;
    localparam logic [2:0] F3_BLT = 3'b100;
    localparam logic [2:0] F3_BGE = 3'b101;

    // first fetch address
    localparam word_t RESET_PC = 32'h3300_0000;

    // sequential PC step, also the JAL link offset
    localparam word_t INSTR_BYTES = 32'd4;

    // all transfers are full words
    localparam logic [3:0] WB_SEL_ALL = 4'b1111;

endpackage

`default_nettype wire

// ==== rv_regfile.sv ====
//////////////////////////////////////////////////
// 32 x 32 register file, two read ports,
// write data from the ALU or the bus
//////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/10ps

module rv_regfile (
    input  logic              clk,
    input  logic              rst,
    input  logic              we_i,
    input  rv_pkg::reg_addr_t rd_i,
    input  rv_pkg::reg_addr_t rs1_i,
    input  rv_pkg::reg_addr_t rs2_i,
    input  rv_pkg::word_t     alu_data_i,
    input  rv_pkg::word_t     mem_data_i,
    input  logic              sel_mem_i,
    output rv_pkg::word_t     rs1_data_o,
    output rv_pkg::word_t     rs2_data_o
);
    import rv_pkg::*;

    word_t regs [0:31];
    word_t wr_data;

    assign wr_data = sel_mem_i ? mem_data_i : alu_data_i;

    // x0 is cleared here and never written
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (rd_i != '0)) begin
            regs[rd_i] <= wr_data;
        end
    end

    assign rs1_data_o = regs[rs1_i];
    assign rs2_data_o = regs[rs2_i];

endmodule

`default_nettype wire

// ==== rv_sequencer.sv ====
//////////////////////////////////////////////////
// instruction sequencer FSM
// fetch, execute and load/store steps, steering
// the bus request, register write and PC update
//////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/10ps

module rv_sequencer (
    input  logic            clk,
    input  logic            rst,
    input  logic            en_i,
    input  rv_pkg::opcode_t opcode_i,
    input  logic            branch_taken_i,
    input  logic            bus_done_i,
    output logic            bus_req_o,
    output logic            bus_we_o,
    output logic            addr_data_o,
    output logic            ir_load_o,
    output logic            rf_we_o,
    output logic            rf_sel_mem_o,
    output logic            pc_step_o,
    output logic            pc_jump_o
);
    import rv_pkg::*;

    typedef enum logic [2:0] {
        HALT,
        FETCH,
        FETCH_WAIT,
        EXECUTE,
        MEM,
        MEM_WAIT
    } seq_state_t;

    seq_state_t state, next_state;
    logic       is_mem;

    assign is_mem = (opcode_i == OP_LOAD) || (opcode_i == OP_STORE);

    // wait in HALT out of reset until enabled
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state <= HALT;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state   = state;
        bus_req_o    = 1'b0;
        bus_we_o     = 1'b0;
        addr_data_o  = 1'b0;
        ir_load_o    = 1'b0;
        rf_we_o      = 1'b0;
        rf_sel_mem_o = 1'b0;
        pc_step_o    = 1'b0;
        pc_jump_o    = 1'b0;
        case (state)
            HALT: begin
                if (en_i) next_state = FETCH;
            end
            FETCH: begin
                bus_req_o  = 1'b1;
                next_state = FETCH_WAIT;
            end
            FETCH_WAIT: begin
                ir_load_o = bus_done_i;
                if (bus_done_i) next_state = EXECUTE;
            end
            EXECUTE: begin
                case (opcode_i)
                    OP_REG, OP_IMM, OP_LUI: begin
                        rf_we_o   = 1'b1;
                        pc_step_o = 1'b1;
                    end
                    OP_JAL: begin
                        rf_we_o   = 1'b1;
                        pc_jump_o = 1'b1;
                    end
                    OP_BRANCH: begin
                        pc_jump_o = branch_taken_i;
                        pc_step_o = !branch_taken_i;
                    end
                    // loads and stores step the PC after the data cycle
                    OP_LOAD, OP_STORE: pc_step_o = 1'b0;
                    default: pc_step_o = 1'b1;
                endcase
                if (is_mem) next_state = MEM;
                else        next_state = en_i ? FETCH : HALT;
            end
            MEM: begin
                bus_req_o   = 1'b1;
                bus_we_o    = (opcode_i == OP_STORE);
                addr_data_o = 1'b1;
                next_state  = MEM_WAIT;
            end
            MEM_WAIT: begin
                addr_data_o  = 1'b1;
                rf_sel_mem_o = 1'b1;
                if (bus_done_i) begin
                    rf_we_o    = (opcode_i == OP_LOAD);
                    pc_step_o  = 1'b1;
                    next_state = en_i ? FETCH : HALT;
                end
            end
            default: next_state = HALT;
        endcase
    end

endmodule

`default_nettype wire

// ==== rv_top.f ====
rv_pkg.sv
rv_decoder.sv
rv_alu.sv
rv_regfile.sv
rv_pc.sv
rv_sequencer.sv
wb_master.sv
rv_top.sv
tb_rv_top.sv

// ==== rv_top.sv ====
//////////////////////////////////////////////////
// top level of the RV32I subset core
// sequencer, datapath and Wishbone master
//////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/10ps

module rv_top (
    input  logic          clk,
    input  logic          rst,
    input  logic          en_i,
    input  rv_pkg::word_t wb_dat_i,
    input  logic          wb_ack_i,
    output rv_pkg::word_t wb_adr_o,
    output rv_pkg::word_t wb_dat_o,
    output logic [3:0]    wb_sel_o,
    output logic          wb_we_o,
    output logic          wb_stb_o,
    output logic          wb_cyc_o
);
    import rv_pkg::*;

    // sequencer controls
    logic bus_req, bus_we, bus_done, addr_data;
    logic ir_load, rf_we, rf_sel_mem, pc_step, pc_jump;

    // decoded fields
    opcode_t    opcode;
    reg_addr_t  rs1, rs2, rd;
    logic [2:0] funct3;
    logic       alt_op, imm_sel;
    word_t      imm;

    // datapath words
    word_t pc, rs1_data, rs2_data, alu_result, alu_addr;
    word_t bus_adr, bus_rdat;
    logic  branch_taken;

    // fetch address or load/store address
    assign bus_adr = addr_data ? alu_addr : pc;

    rv_sequencer seq_i (
        .clk(clk), .rst(rst), .en_i(en_i),
        .opcode_i(opcode), .branch_taken_i(branch_taken), .bus_done_i(bus_done),
        .bus_req_o(bus_req), .bus_we_o(bus_we), .addr_data_o(addr_data),
        .ir_load_o(ir_load), .rf_we_o(rf_we), .rf_sel_mem_o(rf_sel_mem),
        .pc_step_o(pc_step), .pc_jump_o(pc_jump)
    );

    rv_pc pc_i (
        .clk(clk), .rst(rst), .step_i(pc_step), .jump_i(pc_jump),
        .offset_i(imm), .pc_o(pc)
    );

    rv_decoder dec_i (
        .clk(clk), .rst(rst), .load_i(ir_load), .instr_i(bus_rdat),
        .opcode_o(opcode), .rs1_o(rs1), .rs2_o(rs2), .rd_o(rd),
        .funct3_o(funct3), .alt_op_o(alt_op), .imm_o(imm), .imm_sel_o(imm_sel)
    );

    rv_regfile rf_i (
        .clk(clk), .rst(rst), .we_i(rf_we), .rd_i(rd), .rs1_i(rs1), .rs2_i(rs2),
        .alu_data_i(alu_result), .mem_data_i(bus_rdat), .sel_mem_i(rf_sel_mem),
        .rs1_data_o(rs1_data), .rs2_data_o(rs2_data)
    );

    rv_alu alu_i (
        .opcode_i(opcode), .funct3_i(funct3), .alt_op_i(alt_op), .imm_sel_i(imm_sel),
        .rs1_data_i(rs1_data), .rs2_data_i(rs2_data), .imm_i(imm), .pc_i(pc),
        .result_o(alu_result), .addr_o(alu_addr), .branch_taken_o(branch_taken)
    );

    wb_master wb_i (
        .clk(clk), .rst(rst), .req_i(bus_req), .we_i(bus_we),
        .adr_i(bus_adr), .wdat_i(rs2_data), .wb_dat_i(wb_dat_i), .wb_ack_i(wb_ack_i),
        .done_o(bus_done), .rdat_o(bus_rdat),
        .wb_adr_o(wb_adr_o), .wb_dat_o(wb_dat_o), .wb_sel_o(wb_sel_o),
        .wb_we_o(wb_we_o), .wb_stb_o(wb_stb_o), .wb_cyc_o(wb_cyc_o)
    );

endmodule

`default_nettype wire

// ==== tb_rv_top.sv ====
//////////////////////////////////////////////////
// testbench for rv_top
// random program generator, Wishbone slave memory,
// instruction-set reference model and bus checker
//////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/10ps

module tb_rv_top;

    localparam logic [31:0] START_ADDR = 32'h3300_0000;
    localparam logic [31:0] DATA_BASE  = 32'h3400_0000;
    localparam logic [31:0] LOAD_BASE  = 32'h3500_0000;
    // body runs up to the register dump stores, then the final loop
    localparam int BODY_END = 42;
    localparam int PROG_LEN = 59;
    localparam int TIMEOUT  = 20000;
    localparam logic [31:0] LOOP_ADDR = START_ADDR + 4 * (PROG_LEN - 1);

    // add, xor, or, and, sll, srl
    localparam int ALU_F3 [0:5] = '{0, 4, 6, 7, 1, 5};
    // beq, bne, blt, bge
    localparam int BR_F3 [0:3] = '{0, 1, 4, 5};

    logic        clk, rst, en_i;
    logic [31:0] wb_dat_i, wb_adr_o, wb_dat_o;
    logic        wb_ack_i, wb_we_o, wb_stb_o, wb_cyc_o;
    logic [3:0]  wb_sel_o;

    logic [31:0] rng_state = 32'd64347;
    logic [31:0] prog [0:PROG_LEN-1];
    logic [31:0] ld_data [0:255];
    logic [31:0] mem [logic [31:0]];
    logic [31:0] exp_fetch [$];
    logic [31:0] exp_wadr [$];
    logic [31:0] exp_wdat [$];
    logic [31:0] ev_adr [$];
    logic [31:0] ev_dat [$];
    logic        ev_we [$];
    int          fetch_idx = 0;
    int          wr_idx = 0;
    int          error_count = 0;
    bit          aborted = 1'b0;

    rv_top rv_top_i (
        .clk(clk), .rst(rst), .en_i(en_i),
        .wb_dat_i(wb_dat_i), .wb_ack_i(wb_ack_i),
        .wb_adr_o(wb_adr_o), .wb_dat_o(wb_dat_o), .wb_sel_o(wb_sel_o),
        .wb_we_o(wb_we_o), .wb_stb_o(wb_stb_o), .wb_cyc_o(wb_cyc_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // upper LCG bits only as the low ones repeat quickly
    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state >> 8;
    endfunction

    // unwritten memory reads back a pattern of the address
    function automatic logic [31:0] fill_word(logic [31:0] a);
        return {a[15:0], a[31:16]} ^ 32'h9e37_79b9;
    endfunction

    function automatic logic [31:0] enc_r(int f7, int rs2, int rs1, int f3, int rd);
        return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(int op, int imm, int rs1, int f3, int rd);
        return {12'(imm), 5'(rs1), 3'(f3), 5'(rd), 7'(op)};
    endfunction

    function automatic logic [31:0] enc_s(int imm, int rs2, int rs1);
        logic [11:0] i;
        i = 12'(imm);
        return {i[11:5], 5'(rs2), 5'(rs1), 3'b010, i[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_b(int off, int rs2, int rs1, int f3);
        logic [12:0] i;
        i = 13'(off);
        return {i[12], i[10:5], 5'(rs2), 5'(rs1), 3'(f3), i[4:1], i[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_j(int off, int rd);
        logic [20:0] i;
        i = 21'(off);
        return {i[20], i[10:1], i[11], i[19:12], 5'(rd), 7'b1101111};
    endfunction

    function automatic logic [31:0] enc_u(int imm, int rd);
        return {20'(imm), 5'(rd), 7'b0110111};
    endfunction

    // x31 points at the store region, x30 at the load region
    function automatic void build_program();
        int kind, k, rd, rs1, rs2, tgt;
        prog[0] = enc_u(DATA_BASE >> 12, 31);
        prog[1] = enc_u(LOAD_BASE >> 12, 30);
        // write to x0 which must stay zero
        prog[2] = enc_i('h13, 'h3a5, 0, 0, 0);
        for (int i = 3; i < BODY_END; i++) begin
            kind = next_random() % 10;
            k    = next_random() % 7;
            rd   = next_random() % 16;
            rs1  = next_random() % 16;
            rs2  = next_random() % 16;
            tgt  = i + 1 + next_random() % 4;
            if (tgt > BODY_END) tgt = BODY_END;
            case (kind)
                0, 1: begin
                    if (k == 6) prog[i] = enc_r(32, rs2, rs1, 0, rd);
                    else        prog[i] = enc_r(0, rs2, rs1, ALU_F3[k], rd);
                end
                2, 3: begin
                    if (k % 6 < 4) prog[i] = enc_i('h13, next_random() % 4096, rs1,
                                                   ALU_F3[k % 6], rd);
                    else           prog[i] = enc_i('h13, next_random() % 32, rs1,
                                                   ALU_F3[k % 6], rd);
                end
                4:       prog[i] = enc_u(next_random() % 1048576, rd);
                5:       prog[i] = enc_b((tgt - i) * 4, rs2, rs1, BR_F3[k % 4]);
                6:       prog[i] = enc_j((tgt - i) * 4, rd);
                7:       prog[i] = enc_i('h03, 4 * (next_random() % 256), 30, 2, rd);
                default: prog[i] = enc_s(4 * (next_random() % 256), rs2, 31);
            endcase
        end
        // dump x0..x15, then jump to self
        for (int r = 0; r < 16; r++) begin
            prog[BODY_END + r] = enc_s(1024 + 4 * r, r, 31);
        end
        prog[PROG_LEN-1] = enc_j(0, 0);
        for (int i = 0; i < PROG_LEN; i++) begin
            mem[START_ADDR + 4 * i] = prog[i];
        end
        for (int j = 0; j < 256; j++) begin
            ld_data[j] = next_random() ^ (next_random() << 12);
            mem[LOAD_BASE + 4 * j] = ld_data[j];
        end
    endfunction

    function automatic logic [31:0] alu_ref(logic [2:0] f3, logic sub, logic [31:0] a,
                                            logic [31:0] b);
        case (f3)
            3'b000:  return sub ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b100:  return a ^ b;
            3'b101:  return a >> b[4:0];
            3'b110:  return a | b;
            3'b111:  return a & b;
            default: return 32'h0;
        endcase
    endfunction

    // instruction-set model, fills the expected fetch and write lists
    function automatic void run_model();
        logic [31:0] x [0:31];
        logic [31:0] pc, pc_next, ins, imm, res, adr, a, b;
        logic [4:0]  rd;
        logic        taken, done;
        int          steps, idx;
        for (int r = 0; r < 32; r++) x[r] = 32'h0;
        pc    = START_ADDR;
        done  = 1'b0;
        steps = 0;
        while (!done && steps < 2000) begin
            exp_fetch.push_back(pc);
            idx     = (pc - START_ADDR) >> 2;
            ins     = prog[idx];
            rd      = ins[11:7];
            a       = x[ins[19:15]];
            b       = x[ins[24:20]];
            res     = 32'h0;
            pc_next = pc + 32'd4;
            case (ins[6:0])
                7'h33: res = alu_ref(ins[14:12], ins[30], a, b);
                7'h13: res = alu_ref(ins[14:12], 1'b0, a, {{20{ins[31]}}, ins[31:20]});
                7'h37: res = {ins[31:12], 12'h0};
                7'h03: begin
                    adr = a + {{20{ins[31]}}, ins[31:20]};
                    idx = (adr - LOAD_BASE) >> 2;
                    res = ld_data[idx];
                end
                7'h23: begin
                    adr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                    exp_wadr.push_back(adr);
                    exp_wdat.push_back(b);
                    rd = 5'd0;
                end
                7'h63: begin
                    // blt and bge are unsigned in this core
                    case (ins[14:12])
                        3'b000:  taken = (a == b);
                        3'b001:  taken = (a != b);
                        3'b100:  taken = (a < b);
                        default: taken = (a >= b);
                    endcase
                    imm = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
                    if (taken) pc_next = pc + imm;
                    rd = 5'd0;
                end
                7'h6f: begin
                    imm     = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
                    res     = pc + 32'd4;
                    pc_next = pc + imm;
                    done    = (imm == 32'h0);
                end
                default: rd = 5'd0;
            endcase
            if (rd != 5'd0) x[rd] = res;
            pc = pc_next;
            steps++;
        end
    endfunction

    task automatic report_mismatch(string name, logic [31:0] expected, logic [31:0] actual);
        $display("mismatch %s: expected %h, actual %h", name, expected, actual);
        error_count++;
    endtask

    task automatic report_error(string msg);
        $display("error: %s", msg);
        error_count++;
    endtask

    // Wishbone slave with a random 0 to 5 cycle ack delay
    logic [31:0] cur_adr;
    logic        cur_we;
    int          ack_wait;
    bit          busy = 1'b0;

    always @(negedge clk) begin
        if (rst) begin
            wb_ack_i = 1'b0;
            busy = 1'b0;
        end else if (wb_ack_i) begin
            wb_ack_i = 1'b0;
        end else if (busy || (wb_cyc_o && wb_stb_o)) begin
            if (!busy) begin
                busy     = 1'b1;
                cur_adr  = wb_adr_o;
                cur_we   = wb_we_o;
                ack_wait = next_random() % 6;
                ev_adr.push_back(wb_adr_o);
                ev_dat.push_back(wb_dat_o);
                ev_we.push_back(wb_we_o);
                if (wb_sel_o != 4'hf) report_mismatch("byte select", 32'hf, 32'(wb_sel_o));
                if (!wb_we_o && wb_dat_o != 32'h0) report_mismatch("read dat_o", 0, wb_dat_o);
            end else if (!wb_cyc_o || !wb_stb_o) begin
                report_error("cyc or stb fell before ack");
            end else begin
                if (wb_adr_o != cur_adr) report_mismatch("address hold", cur_adr, wb_adr_o);
                if (wb_we_o != cur_we) report_error("write enable changed before ack");
            end
            if (ack_wait == 0) begin
                busy = 1'b0;
                wb_ack_i = 1'b1;
                if (wb_we_o) mem[wb_adr_o] = wb_dat_o;
                else wb_dat_i = mem.exists(wb_adr_o) ? mem[wb_adr_o] : fill_word(wb_adr_o);
            end else begin
                ack_wait--;
            end
        end
    end

    // compare logged bus cycles with the model lists
    always @(posedge clk) begin : compare_events
        logic [31:0] adr, dat, expected;
        logic        we;
        while (ev_adr.size() > 0) begin
            adr = ev_adr.pop_front();
            dat = ev_dat.pop_front();
            we  = ev_we.pop_front();
            if (we) begin
                if (wr_idx >= exp_wadr.size()) begin
                    report_error($sformatf("unexpected write at %h", adr));
                end else begin
                    if (adr != exp_wadr[wr_idx]) begin
                        report_mismatch($sformatf("write %0d address", wr_idx),
                                        exp_wadr[wr_idx], adr);
                    end
                    if (dat != exp_wdat[wr_idx]) begin
                        report_mismatch($sformatf("write %0d data", wr_idx),
                                        exp_wdat[wr_idx], dat);
                    end
                end
                wr_idx++;
            end else if (adr >= START_ADDR && adr < START_ADDR + 4 * PROG_LEN) begin
                // past the list the core spins on the final loop
                expected = (fetch_idx < exp_fetch.size()) ? exp_fetch[fetch_idx] : LOOP_ADDR;
                if (adr != expected)
                    report_mismatch($sformatf("fetch %0d", fetch_idx), expected, adr);
                fetch_idx++;
            end else if (adr < LOAD_BASE || adr >= LOAD_BASE + 1024) begin
                report_error($sformatf("read at %h outside program and load regions", adr));
            end
        end
    end

    initial begin : main_flow
        int n, idle, mark;
        rst      = 1'b1;
        en_i     = 1'b1;
        wb_dat_i = 32'h0;
        wb_ack_i = 1'b0;
        build_program();
        run_model();
        repeat (16) begin
            @(negedge clk);
            if (wb_cyc_o || wb_stb_o || wb_we_o) report_error("bus control high during reset");
        end
        rst = 1'b0;

        n = 0;
        while (!wb_cyc_o && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!wb_cyc_o) begin
            report_error("timeout waiting for the first bus cycle");
            aborted = 1'b1;
        end else begin
            if (wb_we_o) report_error("first bus cycle is a write");
            if (wb_adr_o != START_ADDR) report_mismatch("first fetch", START_ADDR, wb_adr_o);
        end

        // run to the middle of the program, then pause the core
        if (!aborted) begin
            n = 0;
            while (fetch_idx < exp_fetch.size() / 2 && n < TIMEOUT) begin
                @(negedge clk);
                n++;
            end
            if (fetch_idx < exp_fetch.size() / 2) begin
                report_error("timeout before reaching the pause point");
                aborted = 1'b1;
            end
        end
        if (!aborted) begin
            // the instruction in flight was already fetched
            en_i = 1'b0;
            mark = fetch_idx;
            n    = 0;
            idle = 0;
            while (idle < 20 && n < TIMEOUT) begin
                @(negedge clk);
                n++;
                idle = wb_cyc_o ? 0 : idle + 1;
            end
            if (idle < 20) begin
                report_error("bus never went idle after en_i fell");
                aborted = 1'b1;
            end
        end
        if (!aborted) begin
            repeat (60) begin
                @(negedge clk);
                if (wb_cyc_o) report_error("bus cycle started while en_i is low");
            end
            if (fetch_idx != mark) report_error("fetch seen after en_i fell");
            en_i = 1'b1;
            n    = 0;
            while (fetch_idx < exp_fetch.size() + 2 && n < TIMEOUT) begin
                @(negedge clk);
                n++;
            end
            if (fetch_idx < exp_fetch.size() + 2) begin
                report_error("timeout waiting for the program to finish");
                aborted = 1'b1;
            end
        end
        if (!aborted && wr_idx != exp_wadr.size()) begin
            report_error($sformatf("saw %0d writes, model has %0d", wr_idx, exp_wadr.size()));
        end

        $display("fetches %0d of %0d, writes %0d of %0d, errors %0d",
                 fetch_idx, exp_fetch.size(), wr_idx, exp_wadr.size(), error_count);
        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== wb_master.sv ====
//////////////////////////////////////////////////
// Wishbone classic bus master
// single request/done handshake toward the core,
// registered bus outputs
//////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/10ps

module wb_master (
    input  logic          clk,
    input  logic          rst,
    input  logic          req_i,
    input  logic          we_i,
    input  rv_pkg::word_t adr_i,
    input  rv_pkg::word_t wdat_i,
    input  rv_pkg::word_t wb_dat_i,
    input  logic          wb_ack_i,
    output logic          done_o,
    output rv_pkg::word_t rdat_o,
    output rv_pkg::word_t wb_adr_o,
    output rv_pkg::word_t wb_dat_o,
    output logic [3:0]    wb_sel_o,
    output logic          wb_we_o,
    output logic          wb_stb_o,
    output logic          wb_cyc_o
);
    import rv_pkg::*;

    typedef enum logic {
        IDLE,
        ACTIVE
    } wb_state_t;

    wb_state_t state;

    // bus control
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state    <= IDLE;
            done_o   <= 1'b0;
            wb_sel_o <= '0;
            wb_we_o  <= 1'b0;
            wb_stb_o <= 1'b0;
            wb_cyc_o <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state)
                IDLE: begin
                    if (req_i) begin
                        state    <= ACTIVE;
                        wb_sel_o <= WB_SEL_ALL;
                        wb_we_o  <= we_i;
                        wb_stb_o <= 1'b1;
                        wb_cyc_o <= 1'b1;
                    end
                end
                ACTIVE: begin
                    // hold everything until the slave acks
                    if (wb_ack_i) begin
                        state    <= IDLE;
                        done_o   <= 1'b1;
                        wb_sel_o <= '0;
                        wb_we_o  <= 1'b0;
                        wb_stb_o <= 1'b0;
                        wb_cyc_o <= 1'b0;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // address, write data and read data
    always_ff @(posedge clk) begin
        if (state == IDLE && req_i) begin
            wb_adr_o <= adr_i;
            wb_dat_o <= we_i ? wdat_i : '0;
        end
        if (state == ACTIVE && wb_ack_i && !wb_we_o) begin
            rdat_o <= wb_dat_i;
        end
    end

endmodule

`default_nettype wire
